// ==== common/aio_pkg.sv ====
`default_nettype none

package aio_pkg;

	////////////////////
	// Word and address widths
	////////////////////

	localparam int cfg_word_w   = 32;
	localparam int rom_addr_w   = 8;
	localparam int magic_w      = 16;

	// Target memory sizes
	localparam int cons_depth   = 16;
	localparam int cons_addr_w  = 4;
	localparam int chram_depth  = 64;
	localparam int chram_addr_w = 6;

	// Image header tags
	localparam logic [magic_w-1:0] cons_magic  = 16'hC05A;
	localparam logic [magic_w-1:0] chram_magic = 16'hC4A3;

	// Load sequencer states
	localparam logic [1:0] ld_idle  = 2'd0;
	localparam logic [1:0] ld_cons  = 2'd1;
	localparam logic [1:0] ld_chram = 2'd2;

	// Block reader phases
	localparam logic [1:0] rdr_idle = 2'd0;
	localparam logic [1:0] rdr_hdr  = 2'd1;
	localparam logic [1:0] rdr_chk  = 2'd2;
	localparam logic [1:0] rdr_data = 2'd3;

	// Address 0 holds the header, all other words are raw data
	typedef union packed {
		struct packed {
			logic [magic_w-1:0]            magic;
			logic [cfg_word_w-magic_w-1:0] count;
		} hdr;
		logic [cfg_word_w-1:0] raw;
	} cfg_word_u;

endpackage

`default_nettype wire

// ==== flist.f ====
common/aio_pkg.sv
hw/aio_load_fsm.sv
loader/cfg_block_reader.sv
loader/cons_loader.sv
loader/chram_loader.sv
hw/aio_cfg_top.sv
verif/tb_aio_cfg.sv

// ==== hw/aio_cfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aio_cfg_top
	import aio_pkg::*;
(
	input  wire logic                    sys_clk,
	input  wire logic                    glbl_rst_n,

	input  wire logic                    load_ram_en,
	output logic                         load_ram_done,
	output logic                         load_ram_error,

	// Constants boot ROM
	output logic                         cons_rom_rd,
	output logic [rom_addr_w-1:0]        cons_rom_addr,
	input  wire logic [cfg_word_w-1:0]   cons_rom_data,

	// Channel boot ROM
	output logic                         chram_rom_rd,
	output logic [rom_addr_w-1:0]        chram_rom_addr,
	input  wire logic [cfg_word_w-1:0]   chram_rom_data,

	// Memory read ports
	input  wire logic [cons_addr_w-1:0]  cons_rd_addr,
	output logic [cfg_word_w-1:0]        cons_rd_data,
	input  wire logic [chram_addr_w-1:0] chram_rd_addr,
	output logic [cfg_word_w-1:0]        chram_rd_data
);

	logic load_cons_en;
	logic load_cons_done;
	logic load_cons_error;
	logic load_chram_en;
	logic load_chram_done;
	logic load_chram_error;

	aio_load_fsm u_load_fsm (
		.sys_clk          (sys_clk),
		.glbl_rst_n       (glbl_rst_n),
		.load_ram_en      (load_ram_en),
		.load_ram_done    (load_ram_done),
		.load_ram_error   (load_ram_error),
		.load_cons_en     (load_cons_en),
		.load_cons_done   (load_cons_done),
		.load_cons_error  (load_cons_error),
		.load_chram_en    (load_chram_en),
		.load_chram_done  (load_chram_done),
		.load_chram_error (load_chram_error)
	);

	cons_loader u_cons_loader (
		.sys_clk         (sys_clk),
		.glbl_rst_n      (glbl_rst_n),
		.load_cons_en    (load_cons_en),
		.load_cons_done  (load_cons_done),
		.load_cons_error (load_cons_error),
		.cons_rom_rd     (cons_rom_rd),
		.cons_rom_addr   (cons_rom_addr),
		.cons_rom_data   (cons_rom_data),
		.cons_rd_addr    (cons_rd_addr),
		.cons_rd_data    (cons_rd_data)
	);

	chram_loader u_chram_loader (
		.sys_clk          (sys_clk),
		.glbl_rst_n       (glbl_rst_n),
		.load_chram_en    (load_chram_en),
		.load_chram_done  (load_chram_done),
		.load_chram_error (load_chram_error),
		.chram_rom_rd     (chram_rom_rd),
		.chram_rom_addr   (chram_rom_addr),
		.chram_rom_data   (chram_rom_data),
		.chram_rd_addr    (chram_rd_addr),
		.chram_rd_data    (chram_rd_data)
	);

endmodule

`default_nettype wire

// ==== hw/aio_load_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module aio_load_fsm
	import aio_pkg::*;
(
	input  wire logic sys_clk,
	input  wire logic glbl_rst_n,

	input  wire logic load_ram_en,
	output logic      load_ram_done,
	output logic      load_ram_error,

	output logic      load_cons_en,
	input  wire logic load_cons_done,
	input  wire logic load_cons_error,

	output logic      load_chram_en,
	input  wire logic load_chram_done,
	input  wire logic load_chram_error
);

	logic [1:0] state;

	////////////////////
	// Stage sequencing
	////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state          <= ld_idle;
			load_ram_done  <= 1'b0;
			load_ram_error <= 1'b0;
			load_cons_en   <= 1'b0;
			load_chram_en  <= 1'b0;
		end
		else
		begin
			// All outputs are single-cycle pulses
			load_ram_done  <= 1'b0;
			load_ram_error <= 1'b0;
			load_cons_en   <= 1'b0;
			load_chram_en  <= 1'b0;

			case (state)
				ld_idle :
				begin
					if (load_ram_en)
					begin
						load_cons_en <= 1'b1;
						state        <= ld_cons;
					end
				end
				ld_cons :
				begin
					// Error wins over done, channel stage skipped
					if (load_cons_error)
					begin
						load_ram_error <= 1'b1;
						state          <= ld_idle;
					end
					else if (load_cons_done)
					begin
						load_chram_en <= 1'b1;
						state         <= ld_chram;
					end
				end
				ld_chram :
				begin
					if (load_chram_error)
					begin
						load_ram_error <= 1'b1;
						state          <= ld_idle;
					end
					else if (load_chram_done)
					begin
						load_ram_done <= 1'b1;
						state         <= ld_idle;
					end
				end
				default :
					state <= ld_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== loader/cfg_block_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_block_reader
	import aio_pkg::*;
#(
	parameter logic [magic_w-1:0] block_magic = '0,
	parameter int                 max_count   = 1
)
(
	input  wire logic                  sys_clk,
	input  wire logic                  glbl_rst_n,

	input  wire logic                  start,
	output logic                       done,
	output logic                       error,

	output logic                       rom_rd,
	output logic [rom_addr_w-1:0]      rom_addr,
	input  wire logic [cfg_word_w-1:0] rom_data,

	output logic                       wr_en,
	output logic [rom_addr_w-1:0]      wr_addr,
	output logic [cfg_word_w-1:0]      wr_data
);

	cfg_word_u             word;
	logic [1:0]            state;
	logic                  hdr_ok;
	logic [rom_addr_w-1:0] next_addr;
	logic [rom_addr_w-1:0] last_addr;
	logic                  ret_vld;
	logic [rom_addr_w-1:0] ret_addr;
	logic [cfg_word_w-1:0] sum;

	assign word = rom_data;

	// Header is only meaningful in the cycle it returns
	assign hdr_ok = (word.hdr.magic == block_magic) && (word.hdr.count != '0)
		&& (int'(word.hdr.count) <= max_count);

	////////////////////
	// ROM read port
	////////////////////

	always_comb
	begin
		rom_rd   = 1'b0;
		rom_addr = '0;
		case (state)
			rdr_hdr :
				rom_rd = 1'b1;
			rdr_chk :
			begin
				// First data read overlaps the header return
				rom_rd   = hdr_ok;
				rom_addr = rom_addr_w'(1);
			end
			rdr_data :
			begin
				rom_rd   = (next_addr <= last_addr);
				rom_addr = rom_rd ? next_addr : '0;
			end
			default :
				rom_rd = 1'b0;
		endcase
	end

	////////////////////
	// Phase control
	////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state   <= rdr_idle;
			done    <= 1'b0;
			error   <= 1'b0;
			wr_en   <= 1'b0;
			ret_vld <= 1'b0;
		end
		else
		begin
			done    <= 1'b0;
			error   <= 1'b0;
			wr_en   <= 1'b0;
			ret_vld <= rom_rd;

			case (state)
				rdr_idle :
					if (start)
						state <= rdr_hdr;
				rdr_hdr :
					state <= rdr_chk;
				rdr_chk :
				begin
					if (hdr_ok)
						state <= rdr_data;
					else
					begin
						error <= 1'b1;
						state <= rdr_idle;
					end
				end
				rdr_data :
				begin
					// Checksum is the last word returned
					if (ret_vld && (ret_addr == last_addr))
					begin
						done  <= (sum == word.raw);
						error <= (sum != word.raw);
						state <= rdr_idle;
					end
					else if (ret_vld)
						wr_en <= 1'b1;
				end
				default :
					state <= rdr_idle;
			endcase
		end
	end

	// Address tracking, running sum and write payload
	always_ff @(posedge sys_clk)
	begin
		ret_addr <= rom_addr;
		wr_addr  <= ret_addr - 1'b1;
		wr_data  <= word.raw;

		if (state == rdr_chk)
		begin
			next_addr <= rom_addr_w'(2);
			last_addr <= word.hdr.count[rom_addr_w-1:0] + 1'b1;
			sum       <= '0;
		end
		else if (state == rdr_data)
		begin
			if (rom_rd)
				next_addr <= next_addr + 1'b1;
			if (ret_vld && (ret_addr != last_addr))
				sum <= sum + word.raw;
		end
	end

endmodule

`default_nettype wire

// ==== loader/chram_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module chram_loader
	import aio_pkg::*;
(
	input  wire logic                    sys_clk,
	input  wire logic                    glbl_rst_n,

	input  wire logic                    load_chram_en,
	output logic                         load_chram_done,
	output logic                         load_chram_error,

	output logic                         chram_rom_rd,
	output logic [rom_addr_w-1:0]        chram_rom_addr,
	input  wire logic [cfg_word_w-1:0]   chram_rom_data,

	input  wire logic [chram_addr_w-1:0] chram_rd_addr,
	output logic [cfg_word_w-1:0]        chram_rd_data
);

	logic                  wr_en;
	logic [rom_addr_w-1:0] wr_addr;
	logic [cfg_word_w-1:0] wr_data;

	logic [cfg_word_w-1:0] chram_mem [chram_depth];

	cfg_block_reader #(
		.block_magic (chram_magic),
		.max_count   (chram_depth)
	) u_reader (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.start      (load_chram_en),
		.done       (load_chram_done),
		.error      (load_chram_error),
		.rom_rd     (chram_rom_rd),
		.rom_addr   (chram_rom_addr),
		.rom_data   (chram_rom_data),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	////////////////////
	// Channel RAM
	////////////////////

	// Write port driven by the block reader
	always_ff @(posedge sys_clk)
	begin
		if (wr_en)
			chram_mem[wr_addr[chram_addr_w-1:0]] <= wr_data;
	end

	// Read data valid one cycle after the address
	always_ff @(posedge sys_clk)
	begin
		chram_rd_data <= chram_mem[chram_rd_addr];
	end

endmodule

`default_nettype wire

// ==== loader/cons_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module cons_loader
	import aio_pkg::*;
(
	input  wire logic                   sys_clk,
	input  wire logic                   glbl_rst_n,

	input  wire logic                   load_cons_en,
	output logic                        load_cons_done,
	output logic                        load_cons_error,

	output logic                        cons_rom_rd,
	output logic [rom_addr_w-1:0]       cons_rom_addr,
	input  wire logic [cfg_word_w-1:0]  cons_rom_data,

	input  wire logic [cons_addr_w-1:0] cons_rd_addr,
	output logic [cfg_word_w-1:0]       cons_rd_data
);

	logic                  wr_en;
	logic [rom_addr_w-1:0] wr_addr;
	logic [cfg_word_w-1:0] wr_data;

	logic [cfg_word_w-1:0] cons_regs [cons_depth];

	cfg_block_reader #(
		.block_magic (cons_magic),
		.max_count   (cons_depth)
	) u_reader (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.start      (load_cons_en),
		.done       (load_cons_done),
		.error      (load_cons_error),
		.rom_rd     (cons_rom_rd),
		.rom_addr   (cons_rom_addr),
		.rom_data   (cons_rom_data),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	////////////////////
	// Constants register file
	////////////////////

	// Header count limit keeps the write address in range
	always_ff @(posedge sys_clk)
	begin
		if (wr_en)
			cons_regs[wr_addr[cons_addr_w-1:0]] <= wr_data;
	end

	// Combinational read
	assign cons_rd_data = cons_regs[cons_rd_addr];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the configuration loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_aio_cfg -Mdir obj_dir -o tb_aio_cfg -f flist.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_aio_cfg
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0

// ==== verif/aio_cfg_vectors.txt ====
// Records of 128 words, one per case
// base+00: expect_error chram_start busy_pulse
// base+08: constants ROM image (header, data words, checksum)
// base+20: channel ROM image (header, data words, checksum)

// Case 0 good load
@000 00000000 00000001 00000000
@008 C05A0004 00000011 00000022 00000033 00000044 000000AA
@020 C4A30006 10000001 10000002 10000003 10000004 10000005 10000006 60000015

// Case 1 wrong constants magic
@080 00000001 00000000 00000000
@088 BAD00004 00000011 00000022 00000033 00000044 000000AA
@0A0 C4A30001 12345678 12345678

// Case 2 wrong channel checksum
@100 00000001 00000001 00000000
@108 C05A0003 00000101 00000202 00000303 00000606
@120 C4A30004 20000001 20000002 20000003 20000004 8000000B

// Case 3 zero constants count
@180 00000001 00000000 00000000
@188 C05A0000 00000000
@1A0 C4A30001 0000000F 0000000F

// Case 4 channel count above depth
@200 00000001 00000001 00000000
@208 C05A0002 0000A001 0000A002 00014003
@220 C4A30041 00000001

// Case 5 extra start pulse while busy
@280 00000000 00000001 00000001
@288 C05A0005 00000501 00000502 00000503 00000504 00000505 0000190F
@2A0 C4A30003 30000001 30000002 30000003 90000006

// Case 6 second good load, full constants block, sums wrap
@300 00000000 00000001 00000000
@308 C05A0010 70000001 70000002 70000003 70000004 70000005 70000006 70000007 70000008
@311 70000009 7000000A 7000000B 7000000C 7000000D 7000000E 7000000F 70000010 00000088
@320 C4A30008 40000001 40000002 40000003 40000004 40000005 40000006 40000007
@328 40000008 00000024

// ==== verif/tb_aio_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aio_cfg
	import aio_pkg::*;
();

	localparam int case_count     = 7;
	localparam int rec_words      = 128;
	localparam int cons_img       = 8;
	localparam int chram_img      = 32;
	localparam int result_timeout = 400;

	logic                    sys_clk;
	logic                    glbl_rst_n;
	logic                    load_ram_en;
	logic                    load_ram_done;
	logic                    load_ram_error;
	logic                    cons_rom_rd;
	logic [rom_addr_w-1:0]   cons_rom_addr;
	logic [cfg_word_w-1:0]   cons_rom_data;
	logic                    chram_rom_rd;
	logic [rom_addr_w-1:0]   chram_rom_addr;
	logic [cfg_word_w-1:0]   chram_rom_data;
	logic [cons_addr_w-1:0]  cons_rd_addr;
	logic [cfg_word_w-1:0]   cons_rd_data;
	logic [chram_addr_w-1:0] chram_rd_addr;
	logic [cfg_word_w-1:0]   chram_rd_data;

	logic [cfg_word_w-1:0] vec_mem [case_count*rec_words];
	logic [cfg_word_w-1:0] cons_rom [1<<rom_addr_w];
	logic [cfg_word_w-1:0] chram_rom [1<<rom_addr_w];

	// Expected memory contents built up case by case
	logic [cfg_word_w-1:0] exp_cons [cons_depth];
	bit                    cons_known [cons_depth];
	logic [cfg_word_w-1:0] exp_chram [chram_depth];
	bit                    chram_known [chram_depth];

	// Per-case observations
	int case_id        = -1;
	int mon_case       = -1;
	int done_cnt       = 0;
	int err_cnt        = 0;
	bit chram_rd_seen  = 1'b0;
	int cons_max_addr  = 0;
	int chram_max_addr = 0;

	logic                  cons_req  = 1'b0;
	logic                  chram_req = 1'b0;
	logic [rom_addr_w-1:0] cons_req_addr;
	logic [rom_addr_w-1:0] chram_req_addr;

	aio_cfg_top DUT (
		.sys_clk        (sys_clk),
		.glbl_rst_n     (glbl_rst_n),
		.load_ram_en    (load_ram_en),
		.load_ram_done  (load_ram_done),
		.load_ram_error (load_ram_error),
		.cons_rom_rd    (cons_rom_rd),
		.cons_rom_addr  (cons_rom_addr),
		.cons_rom_data  (cons_rom_data),
		.chram_rom_rd   (chram_rom_rd),
		.chram_rom_addr (chram_rom_addr),
		.chram_rom_data (chram_rom_data),
		.cons_rd_addr   (cons_rd_addr),
		.cons_rd_data   (cons_rd_data),
		.chram_rd_addr  (chram_rd_addr),
		.chram_rd_data  (chram_rd_data)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	////////////////////
	// Boot ROM models
	////////////////////

	// Request taken mid-cycle, word returned just after the next edge
	always @(negedge sys_clk)
	begin
		cons_req       <= cons_rom_rd;
		cons_req_addr  <= cons_rom_addr;
		chram_req      <= chram_rom_rd;
		chram_req_addr <= chram_rom_addr;
	end

	always @(posedge sys_clk)
	begin
		#1;
		if (cons_req)
			cons_rom_data = cons_rom[cons_req_addr];
		if (chram_req)
			chram_rom_data = chram_rom[chram_req_addr];
	end

	// Result pulses and ROM traffic of the running case
	always @(negedge sys_clk)
	begin
		if (case_id != mon_case)
		begin
			mon_case       = case_id;
			done_cnt       = 0;
			err_cnt        = 0;
			chram_rd_seen  = 1'b0;
			cons_max_addr  = 0;
			chram_max_addr = 0;
		end
		if (load_ram_done)
			done_cnt++;
		if (load_ram_error)
			err_cnt++;
		if (chram_rom_rd)
			chram_rd_seen = 1'b1;
		if (cons_rom_rd && (int'(cons_rom_addr) > cons_max_addr))
			cons_max_addr = int'(cons_rom_addr);
		if (chram_rom_rd && (int'(chram_rom_addr) > chram_max_addr))
			chram_max_addr = int'(chram_rom_addr);
	end

	////////////////////
	// Error reporting
	////////////////////

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic mismatch_error(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[ERROR] time=%0d ns signal=%s got=%h expected=%h", $time, sig, got, exp);
		abort_run();
	endtask

	task automatic plain_error(input string what);
		$display("[ERROR] time=%0d ns %s", $time, what);
		abort_run();
	endtask

	////////////////////
	// Helpers
	////////////////////

	// Magic must match, count in 1..depth
	function automatic bit hdr_valid(input cfg_word_u w, input logic [magic_w-1:0] magic,
		input int depth);
		return (w.hdr.magic == magic) && (w.hdr.count != '0) && (int'(w.hdr.count) <= depth);
	endfunction

	task automatic load_roms(input int base);
		int a;
		for (a = 0; a < (1 << rom_addr_w); a++)
		begin
			cons_rom[a]  = (a < chram_img - cons_img) ? vec_mem[base+cons_img+a]
				: {16'hE0E0, 8'h00, 8'(a)};
			chram_rom[a] = (a < rec_words - chram_img) ? vec_mem[base+chram_img+a]
				: {16'hE1E1, 8'h00, 8'(a)};
		end
	endtask

	// Data words land at ROM address minus one
	task automatic record_image(input int img_base, input bit to_cons);
		cfg_word_u hdr;
		int        i;
		hdr = vec_mem[img_base];
		for (i = 0; i < int'(hdr.hdr.count); i++)
		begin
			if (to_cons)
			begin
				exp_cons[i]   = vec_mem[img_base+1+i];
				cons_known[i] = 1'b1;
			end
			else
			begin
				exp_chram[i]   = vec_mem[img_base+1+i];
				chram_known[i] = 1'b1;
			end
		end
	endtask

	task automatic wait_for_result();
		int cyc;
		cyc = 0;
		while (((done_cnt + err_cnt) == 0) && (cyc < result_timeout))
		begin
			@(posedge sys_clk);
			cyc++;
		end
		assert (cyc < result_timeout)
		else
			plain_error("load finished with neither load_ram_done nor load_ram_error");
	endtask

	task automatic check_memories();
		int                    i;
		logic [cfg_word_w-1:0] held;
		for (i = 0; i < cons_depth; i++)
		begin
			@(posedge sys_clk);
			#1;
			cons_rd_addr = cons_addr_w'(i);
			#1;
			if (cons_known[i])
				assert (cons_rd_data == exp_cons[i])
				else
					mismatch_error($sformatf("cons_rd_data[%0d]", i), cons_rd_data, exp_cons[i]);
		end
		// Word for address i shows up one edge after it is set
		for (i = 0; i <= chram_depth; i++)
		begin
			@(posedge sys_clk);
			#1;
			held = chram_rd_data;
			if ((i > 0) && chram_known[i-1])
				assert (held == exp_chram[i-1])
				else
					mismatch_error($sformatf("chram_rd_data[%0d]", i - 1), held, exp_chram[i-1]);
			if (i < chram_depth)
				chram_rd_addr = chram_addr_w'(i);
			#1;
			assert (chram_rd_data === held)
			else
				mismatch_error("chram_rd_data before clock edge", chram_rd_data, held);
		end
	endtask

	task automatic run_case(input int c);
		int        base;
		int        gap;
		int        exp_max;
		bit        exp_err;
		bit        chram_start;
		bit        busy_pulse;
		bit        cons_ok;
		bit        chram_ok;
		cfg_word_u cons_hdr;
		cfg_word_u chram_hdr;

		base        = c * rec_words;
		exp_err     = vec_mem[base][0];
		chram_start = vec_mem[base+1][0];
		busy_pulse  = vec_mem[base+2][0];
		cons_hdr    = vec_mem[base+cons_img];
		chram_hdr   = vec_mem[base+chram_img];
		cons_ok     = hdr_valid(cons_hdr, cons_magic, cons_depth);
		chram_ok    = hdr_valid(chram_hdr, chram_magic, chram_depth);
		load_roms(base);

		gap = 2 + int'($urandom % 4);
		repeat (gap) @(posedge sys_clk);

		@(posedge sys_clk);
		#1;
		case_id     = c;
		load_ram_en = 1'b1;
		@(posedge sys_clk);
		#1;
		load_ram_en = 1'b0;

		// Second start while the constants stage still runs
		if (busy_pulse)
		begin
			repeat (3) @(posedge sys_clk);
			#1;
			load_ram_en = 1'b1;
			@(posedge sys_clk);
			#1;
			load_ram_en = 1'b0;
		end

		wait_for_result();
		repeat (12) @(posedge sys_clk);

		assert (chram_rd_seen == chram_start)
		else
			mismatch_error("chram_rom_rd seen", 32'(chram_rd_seen), 32'(chram_start));

		// A rejected header stops the stage after address 0
		exp_max = cons_ok ? int'(cons_hdr.hdr.count) + 1 : 0;
		assert (cons_max_addr == exp_max)
		else
			mismatch_error("cons_rom_addr highest read", cons_max_addr, exp_max);
		if (cons_ok)
			record_image(base + cons_img, 1'b1);

		if (chram_start)
		begin
			exp_max = chram_ok ? int'(chram_hdr.hdr.count) + 1 : 0;
			assert (chram_max_addr == exp_max)
			else
				mismatch_error("chram_rom_addr highest read", chram_max_addr, exp_max);
			if (chram_ok)
				record_image(base + chram_img, 1'b0);
		end

		check_memories();

		// Pulses counted over the whole readback, long enough for a second load
		assert (done_cnt == (exp_err ? 0 : 1))
		else
			mismatch_error("load_ram_done pulse count", done_cnt, exp_err ? 0 : 1);
		assert (err_cnt == (exp_err ? 1 : 0))
		else
			mismatch_error("load_ram_error pulse count", err_cnt, exp_err ? 1 : 0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		int i;
		glbl_rst_n     = 1'b0;
		load_ram_en    = 1'b0;
		cons_rom_data  = '0;
		chram_rom_data = '0;
		cons_rd_addr   = '0;
		chram_rd_addr  = '0;
		void'($urandom(83));

		for (i = 0; i < case_count * rec_words; i++)
			vec_mem[i] = 32'hF000_0000 | 32'(i);
		$readmemh("verif/aio_cfg_vectors.txt", vec_mem);

		repeat (8) @(posedge sys_clk);
		#1;
		glbl_rst_n = 1'b1;

		for (i = 0; i < case_count; i++)
			run_case(i);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
